// ==== hdl/div_params.svh ====
`ifndef DIV_PARAMS_SVH
`define DIV_PARAMS_SVH

// operand and result width
`define DIV_DATA_WIDTH 32

// register file size, selector width to match
`define DIV_NUM_REGS 32
`define DIV_SEL_WIDTH 5

// bit position counter, counts DIV_DATA_WIDTH-1 down to 0
`define DIV_POS_WIDTH 5

`endif

// ==== hdl/div_pkg.sv ====
`include "div_params.svh"

package div_pkg;

    // one divide operation as presented by the client
    typedef struct packed {
        logic [`DIV_DATA_WIDTH-1:0] a;
        logic [`DIV_DATA_WIDTH-1:0] b;
        // 0 means no quotient write
        logic [`DIV_SEL_WIDTH-1:0]  quot_sel;
        // 0 means no remainder write
        logic [`DIV_SEL_WIDTH-1:0]  mod_sel;
    } div_req_t;

    // single register file write
    typedef struct packed {
        logic [`DIV_SEL_WIDTH-1:0]  sel;
        logic [`DIV_DATA_WIDTH-1:0] data;
    } rf_wr_t;

endpackage

// ==== hdl/div_datapath.sv ====
`timescale 1ns/1ps
`include "div_params.svh"

module div_datapath (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       load,
    input  logic                       step,
    input  logic [`DIV_DATA_WIDTH-1:0] a,
    input  logic [`DIV_DATA_WIDTH-1:0] b,
    output logic [`DIV_DATA_WIDTH-1:0] quotient,
    output logic [`DIV_DATA_WIDTH-1:0] remainder,
    output logic                       last_step
);

    logic [`DIV_POS_WIDTH-1:0]    pos;
    logic [`DIV_DATA_WIDTH-1:0]   divisor;
    // divisor moved up to the current bit, double width so no bits drop
    logic [2*`DIV_DATA_WIDTH-1:0] shifted_b;
    logic                         fits;

    assign shifted_b = {{`DIV_DATA_WIDTH{1'b0}}, divisor} << pos;
    // equal counts as a fit so exact multiples come out clean
    assign fits      = shifted_b <= {{`DIV_DATA_WIDTH{1'b0}}, remainder};
    assign last_step = (pos == '0);

    // bit position, msb first
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pos <= '0;
        end else if (load) begin
            pos <= `DIV_POS_WIDTH'(`DIV_DATA_WIDTH - 1);
        end else if (step && pos != '0) begin
            pos <= pos - 1'b1;
        end
    end

    // quotient and partial remainder
    always_ff @(posedge clk) begin
        if (load) begin
            quotient  <= '0;
            remainder <= a;
            divisor   <= b;
        end else if (step) begin
            // zero divisor always fits, so every bit sets and nothing is taken
            if (fits) begin
                remainder     <= remainder - shifted_b[`DIV_DATA_WIDTH-1:0];
                quotient[pos] <= 1'b1;
            end
        end
    end

endmodule

// ==== hdl/div_ctrl.sv ====
`timescale 1ns/1ps
`include "div_params.svh"

module div_ctrl import div_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       req,
    input  div_req_t                   op,
    input  logic                       last_step,
    input  logic [`DIV_DATA_WIDTH-1:0] quotient,
    input  logic [`DIV_DATA_WIDTH-1:0] remainder,
    input  logic                       rf_wr_ack,
    output logic                       busy,
    output logic                       load,
    output logic                       step,
    output logic [`DIV_DATA_WIDTH-1:0] a,
    output logic [`DIV_DATA_WIDTH-1:0] b,
    output rf_wr_t                     rf_wr,
    output logic                       rf_wr_req
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CALC,
        ST_WR_QUOT,
        ST_WR_REM
    } state_t;

    state_t                     state_q;
    state_t                     state_d;
    logic                       busy_d;
    logic                       wr_req_d;
    logic [`DIV_SEL_WIDTH-1:0]  wr_sel_q;
    logic [`DIV_SEL_WIDTH-1:0]  wr_sel_d;
    // destinations captured at acceptance
    logic [`DIV_SEL_WIDTH-1:0]  quot_sel_q;
    logic [`DIV_SEL_WIDTH-1:0]  mod_sel_q;

    // accept only when idle, datapath loads on the same edge
    assign load = (state_q == ST_IDLE) && req;
    assign a    = op.a;
    assign b    = op.b;
    // one bit per clock for the whole calc state
    assign step = (state_q == ST_CALC);

    // write data comes straight from the held datapath results
    always_comb begin
        rf_wr.sel  = wr_sel_q;
        rf_wr.data = (state_q == ST_WR_REM) ? remainder : quotient;
    end

    always_comb begin
        state_d  = state_q;
        busy_d   = busy;
        wr_req_d = rf_wr_req;
        wr_sel_d = wr_sel_q;
        case (state_q)
            ST_IDLE: begin
                if (req) begin
                    state_d = ST_CALC;
                    busy_d  = 1'b1;
                end
            end
            ST_CALC: begin
                // final bit lands on this edge, pick the first write
                if (last_step) begin
                    if (quot_sel_q != '0) begin
                        state_d  = ST_WR_QUOT;
                        wr_req_d = 1'b1;
                        wr_sel_d = quot_sel_q;
                    end else if (mod_sel_q != '0) begin
                        state_d  = ST_WR_REM;
                        wr_req_d = 1'b1;
                        wr_sel_d = mod_sel_q;
                    end else begin
                        // nothing to write back
                        state_d = ST_IDLE;
                        busy_d  = 1'b0;
                    end
                end
            end
            ST_WR_QUOT: begin
                if (rf_wr_ack) begin
                    if (mod_sel_q != '0) begin
                        // swap in the remainder write, request stays up
                        state_d  = ST_WR_REM;
                        wr_sel_d = mod_sel_q;
                    end else begin
                        state_d  = ST_IDLE;
                        wr_req_d = 1'b0;
                        busy_d   = 1'b0;
                    end
                end
            end
            ST_WR_REM: begin
                if (rf_wr_ack) begin
                    state_d  = ST_IDLE;
                    wr_req_d = 1'b0;
                    busy_d   = 1'b0;
                end
            end
            default: begin
                state_d  = ST_IDLE;
                wr_req_d = 1'b0;
                busy_d   = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q   <= ST_IDLE;
            busy      <= 1'b0;
            rf_wr_req <= 1'b0;
            wr_sel_q  <= '0;
        end else begin
            state_q   <= state_d;
            busy      <= busy_d;
            rf_wr_req <= wr_req_d;
            wr_sel_q  <= wr_sel_d;
        end
    end

    // selectors held for the whole operation
    always_ff @(posedge clk) begin
        if (load) begin
            quot_sel_q <= op.quot_sel;
            mod_sel_q  <= op.mod_sel;
        end
    end

endmodule

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ps
`include "div_params.svh"

module reg_file import div_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  rf_wr_t                     rf_wr,
    input  logic                       rf_wr_req,
    input  logic [`DIV_SEL_WIDTH-1:0]  rd_sel,
    output logic                       rf_wr_ack,
    output logic [`DIV_DATA_WIDTH-1:0] rd_data
);

    logic [`DIV_DATA_WIDTH-1:0] regs [`DIV_NUM_REGS];
    logic                       wr_fire;

    // a held request writes once, the ack cycle blocks a repeat
    assign wr_fire = rf_wr_req && !rf_wr_ack;

    // ack is a single cycle pulse after the write edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rf_wr_ack <= 1'b0;
        end else begin
            rf_wr_ack <= wr_fire;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `DIV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_fire && rf_wr.sel != '0) begin
            // x0 never takes a write
            regs[rf_wr.sel] <= rf_wr.data;
        end
    end

    // combinational read, x0 forced to zero
    always_comb begin
        if (rd_sel == '0) begin
            rd_data = '0;
        end else begin
            rd_data = regs[rd_sel];
        end
    end

endmodule

// ==== hdl/div_subsystem.sv ====
`timescale 1ns/1ps
`include "div_params.svh"

module div_subsystem import div_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       req,
    input  div_req_t                   op,
    input  logic [`DIV_SEL_WIDTH-1:0]  rd_sel,
    output logic                       busy,
    output logic [`DIV_DATA_WIDTH-1:0] rd_data
);

    // controller to datapath
    logic                       load;
    logic                       step;
    logic [`DIV_DATA_WIDTH-1:0] a;
    logic [`DIV_DATA_WIDTH-1:0] b;
    // datapath back to controller
    logic                       last_step;
    logic [`DIV_DATA_WIDTH-1:0] quotient;
    logic [`DIV_DATA_WIDTH-1:0] remainder;
    // write port
    rf_wr_t                     rf_wr;
    logic                       rf_wr_req;
    logic                       rf_wr_ack;

    div_ctrl u_ctrl (
        .clk(clk), .rst(rst),
        .req(req), .op(op),
        .last_step(last_step), .quotient(quotient), .remainder(remainder),
        .rf_wr_ack(rf_wr_ack),
        .busy(busy), .load(load), .step(step), .a(a), .b(b),
        .rf_wr(rf_wr), .rf_wr_req(rf_wr_req)
    );

    div_datapath u_datapath (
        .clk(clk), .rst(rst),
        .load(load), .step(step), .a(a), .b(b),
        .quotient(quotient), .remainder(remainder), .last_step(last_step)
    );

    reg_file u_reg_file (
        .clk(clk), .rst(rst),
        .rf_wr(rf_wr), .rf_wr_req(rf_wr_req), .rd_sel(rd_sel),
        .rf_wr_ack(rf_wr_ack), .rd_data(rd_data)
    );

endmodule

// ==== tb/div_subsystem_assert.sv ====
`timescale 1ns/1ps
`include "div_params.svh"

module div_subsystem_assert import div_pkg::*; (
    input logic   clk,
    input logic   rst,
    input logic   busy,
    input rf_wr_t rf_wr,
    input logic   rf_wr_req,
    input logic   rf_wr_ack
);

    // ack only follows an edge with the request up
    ack_after_req: assert property (
        @(posedge clk) disable iff (rst) rf_wr_ack |-> $past(rf_wr_req)
    ) else $error("rf_wr_ack high without a request on the previous edge");

    // writes only happen inside an operation
    req_in_busy: assert property (
        @(posedge clk) disable iff (rst) rf_wr_req |-> busy
    ) else $error("rf_wr_req high while busy is low");

    // controller never asks for x0
    sel_nonzero: assert property (
        @(posedge clk) disable iff (rst) rf_wr_req |-> (rf_wr.sel != '0)
    ) else $error("register write requested to selector 0");

    // held until the ack is seen
    wr_stable: assert property (
        @(posedge clk) disable iff (rst) $past(rf_wr_req && !rf_wr_ack) |-> $stable(rf_wr)
    ) else $error("rf_wr changed while waiting for rf_wr_ack");

endmodule

bind div_subsystem div_subsystem_assert u_assert (
    .clk(clk),
    .rst(rst),
    .busy(busy),
    .rf_wr(rf_wr),
    .rf_wr_req(rf_wr_req),
    .rf_wr_ack(rf_wr_ack)
);

// ==== tb/div_subsystem_tb.sv ====
`timescale 1ns/1ps
`include "div_params.svh"

module div_subsystem_tb import div_pkg::*; ();

    localparam int NUM_FIXED   = 12;
    localparam int NUM_ENTRIES = 20;
    // reset, then about 40 cycles per entry, plus slack
    localparam int unsigned CYCLE_LIMIT = 16 + 40 * NUM_ENTRIES + 100;

    // one table row, the operation plus a stray req flag
    typedef struct packed {
        div_req_t op;
        logic     extra_req;
    } test_entry_t;

    logic                       clk;
    logic                       rst;
    logic                       req;
    div_req_t                   op;
    logic [`DIV_SEL_WIDTH-1:0]  rd_sel;
    logic                       busy;
    logic [`DIV_DATA_WIDTH-1:0] rd_data;

    test_entry_t                table_mem [NUM_ENTRIES];
    // expected register contents
    logic [`DIV_DATA_WIDTH-1:0] shadow [`DIV_NUM_REGS];
    integer                     seed = 32'hd94b;
    int unsigned                cycle_count = 0;

    div_subsystem DUT (
        .clk(clk), .rst(rst),
        .req(req), .op(op), .rd_sel(rd_sel),
        .busy(busy), .rd_data(rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // hang guard
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Checks failed");
            $fatal(1, "timeout, the run went past %0d cycles", CYCLE_LIMIT);
        end
    end

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("Fail at %0t: %s, got %h, expected %h", $time, what, got, exp);
            $display("Checks failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // unsigned divide rule, zero divisor gives all ones and the dividend
    task automatic calc_expected(input logic [31:0] a, input logic [31:0] b,
                                 output logic [31:0] q, output logic [31:0] r);
        if (b == 32'd0) begin
            q = '1;
            r = a;
        end else begin
            q = a / b;
            r = a % b;
        end
    endtask

    task automatic set_row(input int idx, input logic [31:0] a, input logic [31:0] b,
                           input logic [4:0] qs, input logic [4:0] ms, input logic extra);
        table_mem[idx].op.a        = a;
        table_mem[idx].op.b        = b;
        table_mem[idx].op.quot_sel = qs;
        table_mem[idx].op.mod_sel  = ms;
        table_mem[idx].extra_req   = extra;
    endtask

    task automatic build_table();
        logic [31:0] rnd_a;
        logic [31:0] rnd_b;
        logic [31:0] rnd_c;
        set_row(0, 32'd100, 32'd7, 5'd1, 5'd2, 1'b0);
        // exact multiples
        set_row(1, 32'd144, 32'd12, 5'd3, 5'd4, 1'b0);
        set_row(2, 32'hffff_ffff, 32'd1, 5'd5, 5'd6, 1'b0);
        set_row(3, 32'd7, 32'd100, 5'd7, 5'd8, 1'b0);
        // divide by zero
        set_row(4, 32'd12345, 32'd0, 5'd9, 5'd10, 1'b0);
        // remainder only, then quotient only
        set_row(5, 32'd57, 32'd5, 5'd0, 5'd11, 1'b0);
        set_row(6, 32'd1000, 32'd3, 5'd12, 5'd0, 1'b0);
        // no writes at all
        set_row(7, 32'd999, 32'd9, 5'd0, 5'd0, 1'b0);
        // same target, remainder lands last
        set_row(8, 32'd50, 32'd7, 5'd13, 5'd13, 1'b0);
        set_row(9, 32'd81, 32'd9, 5'd14, 5'd15, 1'b1);
        set_row(10, 32'h8000_0000, 32'h8000_0000, 5'd16, 5'd17, 1'b0);
        set_row(11, 32'hdead_beef, 32'h0001_0000, 5'd1, 5'd2, 1'b1);
        // random rows, divisor shifted down for a spread of quotient sizes
        for (int i = NUM_FIXED; i < NUM_ENTRIES; i++) begin
            rnd_a = $random(seed);
            rnd_b = $random(seed);
            rnd_c = $random(seed);
            set_row(i, rnd_a, rnd_b >> rnd_c[4:0], rnd_c[9:5], rnd_c[14:10], rnd_c[15]);
        end
    endtask

    // drive on the falling edge, sample in the low phase
    task automatic read_reg(input logic [4:0] sel, input int idx);
        logic [31:0] exp;
        @(negedge clk);
        rd_sel = sel;
        #1;
        // x0 always reads zero
        exp = (sel == '0) ? '0 : shadow[sel];
        check_value(rd_data, exp, $sformatf("entry %0d register %0d", idx, sel));
    endtask

    task automatic run_entry(input int idx);
        test_entry_t e;
        logic [31:0] q;
        logic [31:0] r;
        e = table_mem[idx];
        @(negedge clk);
        op  = e.op;
        req = 1'b1;
        @(negedge clk);
        req = 1'b0;
        check_value({31'b0, busy}, 32'd1, $sformatf("entry %0d busy after accept", idx));
        // stray request mid calc, must be dropped
        if (e.extra_req) begin
            repeat (3) @(negedge clk);
            op.a        = ~e.op.a;
            op.b        = e.op.b ^ 32'h0000_00ff;
            op.quot_sel = e.op.mod_sel ^ 5'h1f;
            op.mod_sel  = e.op.quot_sel ^ 5'h0f;
            req         = 1'b1;
            @(negedge clk);
            req = 1'b0;
        end
        // calc plus the register writes
        while (busy) begin
            @(negedge clk);
        end
        calc_expected(e.op.a, e.op.b, q, r);
        // quotient first, remainder second
        if (e.op.quot_sel != '0) begin
            shadow[e.op.quot_sel] = q;
        end
        if (e.op.mod_sel != '0) begin
            shadow[e.op.mod_sel] = r;
        end
        read_reg(e.op.quot_sel, idx);
        read_reg(e.op.mod_sel, idx);
        read_reg(5'd0, idx);
        // some other register, should be untouched
        read_reg(5'(idx * 7 + 3), idx);
    endtask

    initial begin
        rst    = 1'b1;
        req    = 1'b0;
        op     = '0;
        rd_sel = '0;
        for (int s = 0; s < `DIV_NUM_REGS; s++) begin
            shadow[s] = '0;
        end
        build_table();
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            run_entry(i);
        end
        // full sweep catches any stray write
        for (int s = 0; s < `DIV_NUM_REGS; s++) begin
            read_reg(5'(s), NUM_ENTRIES);
        end
        $display("All checks passed");
        $finish;
    end

endmodule

// ==== div_subsystem.f ====
+incdir+hdl
hdl/div_pkg.sv
hdl/div_datapath.sv
hdl/div_ctrl.sv
hdl/reg_file.sv
hdl/div_subsystem.sv
tb/div_subsystem_assert.sv
tb/div_subsystem_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the divide unit testbench with Verilator
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -f div_subsystem.f \
        --top-module div_subsystem_tb -o sim_div_subsystem \
    && ./obj_dir/sim_div_subsystem \
    || { echo "simulation did not complete successfully"; exit 1; }
